// File: include/hps_macros.svh
`ifndef HPS_MACROS_SVH
`define HPS_MACROS_SVH

// host bus handshake
`define HPS_WAIT_CYCLES 8 // io_wait high time per strobe

// answer to the UART flags query
`define HPS_UART_FLAGS 16'b000_11111_000_11111

// default signed PLL phase steps per SDRAM size
`define HPS_PH32 2
`define HPS_PH64 -3
`define HPS_PH128 4

// video measurement
`define HPS_RESTABLE_FRAMES 15 // equal frames before a new resolution counts
`define HPS_VID_W 32 // width of the size and timing results
`define HPS_NRES_W 8 // width of the resolution change counter

`endif

// File: src/hps_io_top.sv
`timescale 1ns/1ps
`include "hps_macros.svh"

module hps_io_top import hps_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        io_ena,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	output logic [15:0] io_dout,
	output logic        io_wait,
	output logic [15:0] joy0,
	output logic [15:0] joy1,
	output logic [15:0] joy2,
	output logic [15:0] joy3,
	output logic [1:0]  buttons,
	output logic [3:0]  conf,
	output logic [2:0]  mouse_buttons,
	output logic        kbd_mouse_strobe,
	output logic        kms_level,
	output kms_type_t   kbd_mouse_type,
	output logic [7:0]  kbd_mouse_data,
	input  logic        ce_pix,
	input  logic        de,
	input  logic        hs,
	input  logic        vs,
	input  logic [11:0] scr_hbl_l,
	input  logic [11:0] scr_hbl_r,
	input  logic [11:0] scr_hsize,
	input  logic [11:0] scr_vbl_t,
	input  logic [11:0] scr_vbl_b,
	input  logic [11:0] scr_vsize,
	input  logic [6:0]  scr_flg,
	input  logic [1:0]  scr_res,
	output logic [11:0] shbl_l,
	output logic [11:0] shbl_r,
	output logic [11:0] svbl_t,
	output logic [11:0] svbl_b,
	output logic        sset,
	output logic [15:0] sdram_sz,
	output logic [63:0] rtc,
	input  logic        pll_locked,
	input  logic        phase_done,
	output logic        phase_en,
	output logic        updn,
	output logic        ready
);

	// decoded write stream shared by all register blocks
	logic        wr_stb;
	logic [5:0]  wr_idx;
	hps_cmd_t    wr_cmd;
	logic [15:0] wr_data;
	logic        frame_end;

	logic [`HPS_NRES_W-1:0] vid_nres;
	logic [`HPS_VID_W-1:0]  vid_hcnt, vid_vcnt, vid_htime, vid_vtime;

	io_frame_decoder u_decoder (
		.clk, .reset, .io_ena, .io_strobe, .io_din, .io_wait,
		.wr_stb, .wr_idx, .wr_cmd, .wr_data, .frame_end
	);

	input_regs u_inputs (
		.clk, .reset, .wr_stb, .wr_idx, .wr_cmd, .wr_data,
		.joy0, .joy1, .joy2, .joy3, .buttons, .conf, .mouse_buttons,
		.kbd_mouse_strobe, .kms_level, .kbd_mouse_type, .kbd_mouse_data
	);

	sys_regs u_sys (
		.clk, .reset, .wr_stb, .wr_idx, .wr_cmd, .wr_data, .frame_end,
		.scr_hbl_l, .scr_hbl_r, .scr_hsize, .scr_vbl_t, .scr_vbl_b, .scr_vsize,
		.scr_flg, .scr_res,
		.vid_nres, .vid_hcnt, .vid_vcnt, .vid_htime, .vid_vtime,
		.io_dout, .rtc, .sdram_sz, .shbl_l, .shbl_r, .svbl_t, .svbl_b, .sset
	);

	vid_measure u_vid (
		.clk, .reset, .ce_pix, .de, .hs, .vs,
		.nres(vid_nres), .hcnt(vid_hcnt), .vcnt(vid_vcnt),
		.htime(vid_htime), .vtime(vid_vtime)
	);

	phase_shift u_phase (
		.clk, .reset, .pll_locked, .phase_done, .sdram_sz,
		.phase_en, .updn, .ready
	);

endmodule

// File: src/hps_pkg.sv
package hps_pkg;

	// command byte carried in word 0 of a frame
	typedef enum logic [7:0] {
		CMD_BUTTONS     = 8'h01,
		CMD_JOY0        = 8'h02,
		CMD_JOY1        = 8'h03,
		CMD_MOUSE       = 8'h04,
		CMD_KEYBOARD    = 8'h05,
		CMD_OSD_KBD     = 8'h06,
		CMD_JOY2        = 8'h10,
		CMD_JOY3        = 8'h11,
		CMD_RTC         = 8'h22,
		CMD_VIDEO_INFO  = 8'h23,
		CMD_UART_FLAGS  = 8'h28,
		CMD_CAP_A       = 8'h2B,
		CMD_SCREEN_INFO = 8'h2C,
		CMD_SCALER_SET  = 8'h2D,
		CMD_CAP_B       = 8'h2F,
		CMD_SDRAM_SIZE  = 8'h31
	} hps_cmd_t;

	// keyboard/mouse event kind
	typedef enum logic [1:0] {
		KMS_MOUSE_X = 2'd0,
		KMS_MOUSE_Y = 2'd1,
		KMS_KEYCODE = 2'd2,
		KMS_OSD_KEY = 2'd3
	} kms_type_t;

endpackage

// File: src/input_regs.sv
`timescale 1ns/1ps

module input_regs import hps_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        wr_stb,
	input  logic [5:0]  wr_idx,
	input  hps_cmd_t    wr_cmd,
	input  logic [15:0] wr_data,
	output logic [15:0] joy0,
	output logic [15:0] joy1,
	output logic [15:0] joy2,
	output logic [15:0] joy3,
	output logic [1:0]  buttons,
	output logic [3:0]  conf,
	output logic [2:0]  mouse_buttons,
	output logic        kbd_mouse_strobe,
	output logic        kms_level,
	output kms_type_t   kbd_mouse_type,
	output logic [7:0]  kbd_mouse_data
);

	logic      ev_fire;
	kms_type_t ev_type;

	// which word of which frame raises a keyboard/mouse event
	always_comb begin
		ev_fire = 1'b0;
		ev_type = KMS_MOUSE_X;
		if (wr_stb) begin
			case (wr_cmd)
				CMD_MOUSE: begin
					if (wr_idx == 6'd1) begin
						ev_fire = 1'b1;
					end else if (wr_idx == 6'd2) begin
						ev_fire = 1'b1;
						ev_type = KMS_MOUSE_Y;
					end
				end
				CMD_KEYBOARD: begin
					ev_fire = (wr_idx == 6'd1);
					ev_type = KMS_KEYCODE;
				end
				CMD_OSD_KBD: begin
					ev_fire = (wr_idx == 6'd1);
					ev_type = KMS_OSD_KEY;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			joy0             <= '0;
			joy1             <= '0;
			joy2             <= '0;
			joy3             <= '0;
			buttons          <= '0;
			conf             <= '0;
			mouse_buttons    <= '0;
			kbd_mouse_strobe <= 1'b0;
			kms_level        <= 1'b0;
		end else begin
			kbd_mouse_strobe <= ev_fire;
			if (ev_fire)
				kms_level <= ~kms_level; // level follows every event

			if (wr_stb && wr_idx == 6'd1) begin
				case (wr_cmd)
					CMD_BUTTONS: begin
						buttons <= wr_data[1:0];
						conf    <= wr_data[7:4];
					end
					CMD_JOY0: joy0 <= wr_data;
					CMD_JOY1: joy1 <= wr_data;
					CMD_JOY2: joy2 <= wr_data;
					CMD_JOY3: joy3 <= wr_data;
					default: ;
				endcase
			end

			if (wr_stb && wr_cmd == CMD_MOUSE && wr_idx == 6'd3)
				mouse_buttons <= wr_data[2:0]; // third payload word holds the buttons
		end
	end

	always_ff @(posedge clk) begin
		if (ev_fire) begin
			kbd_mouse_type <= ev_type;
			kbd_mouse_data <= wr_data[7:0];
		end
	end

	// decoder spacing keeps events at least a cycle apart
	a_strobe_single: assert property (@(posedge clk) disable iff (reset)
		kbd_mouse_strobe |=> !kbd_mouse_strobe)
		else $error("kbd_mouse_strobe high two cycles in a row");

endmodule

// File: src/io_frame_decoder.sv
`timescale 1ns/1ps
`include "hps_macros.svh"

module io_frame_decoder import hps_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        io_ena,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	output logic        io_wait,
	output logic        wr_stb,
	output logic [5:0]  wr_idx,
	output hps_cmd_t    wr_cmd,
	output logic [15:0] wr_data,
	output logic        frame_end
);

	localparam int WAIT_W = $clog2(`HPS_WAIT_CYCLES + 1);

	logic [5:0]        cnt; // word position of the next strobe
	logic [WAIT_W-1:0] wait_cnt;
	logic              end_pend; // frame just closed, report next cycle

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt       <= '0;
			io_wait   <= 1'b0;
			wait_cnt  <= '0;
			wr_stb    <= 1'b0;
			wr_idx    <= '0;
			wr_cmd    <= hps_cmd_t'(8'h00);
			end_pend  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			wr_stb    <= 1'b0;
			end_pend  <= ~io_ena & (cnt != '0);
			frame_end <= end_pend;

			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;
			else
				io_wait <= 1'b0;

			if (!io_ena) begin
				// frame over, drop everything at once
				cnt      <= '0;
				io_wait  <= 1'b0;
				wait_cnt <= '0;
			end else if (io_strobe) begin
				wait_cnt <= WAIT_W'(`HPS_WAIT_CYCLES - 1);
				io_wait  <= 1'b1;
				wr_stb   <= 1'b1;
				wr_idx   <= cnt;
				if (cnt == '0)
					wr_cmd <= hps_cmd_t'(io_din[7:0]); // command stays latched for the frame
				if (~&cnt)
					cnt <= cnt + 1'b1; // saturate on long frames
			end
		end
	end

	always_ff @(posedge clk) begin
		if (io_ena && io_strobe)
			wr_data <= io_din;
	end

	// host must honour the wait window
	a_no_strobe_in_wait: assert property (@(posedge clk) disable iff (reset)
		io_strobe |-> !io_wait)
		else $error("io_strobe while io_wait high");

endmodule

// File: src/phase_shift.sv
`timescale 1ns/1ps
`include "hps_macros.svh"

module phase_shift #(
	parameter int signed m32mb  = `HPS_PH32,
	parameter int signed m64mb  = `HPS_PH64,
	parameter int signed m128mb = `HPS_PH128
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        pll_locked,
	input  logic        phase_done,
	input  logic [15:0] sdram_sz,
	output logic        phase_en,
	output logic        updn,
	output logic        ready
);

	localparam int MAG32  = (m32mb  < 0) ? -m32mb  : m32mb;
	localparam int MAG64  = (m64mb  < 0) ? -m64mb  : m64mb;
	localparam int MAG128 = (m128mb < 0) ? -m128mb : m128mb;
	localparam bit UP32   = (m32mb  >= 0);
	localparam bit UP64   = (m64mb  >= 0);
	localparam bit UP128  = (m128mb >= 0);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SIZE,
		ST_NEXT,
		ST_WAIT_LO,
		ST_WAIT_HI,
		ST_READY
	} state_t;

	state_t     state;
	logic [7:0] steps; // steps still to issue

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= ST_IDLE;
			steps    <= '0;
			phase_en <= 1'b0;
			updn     <= 1'b0;
			ready    <= 1'b0;
		end else begin
			phase_en <= 1'b0; // single-cycle request
			case (state)
				ST_IDLE: begin
					ready <= 1'b0;
					if (pll_locked)
						state <= ST_SIZE;
				end
				ST_SIZE: begin
					if (sdram_sz[15]) begin
						if (sdram_sz[14]) begin
							// debug mode, count and direction come from the host
							steps <= sdram_sz[7:0];
							updn  <= sdram_sz[8];
						end else begin
							case (sdram_sz[1:0])
								2'd0: steps <= '0;
								2'd1: begin
									steps <= 8'(MAG32);
									updn  <= UP32;
								end
								2'd2: begin
									steps <= 8'(MAG64);
									updn  <= UP64;
								end
								default: begin
									steps <= 8'(MAG128);
									updn  <= UP128;
								end
							endcase
						end
						state <= ST_NEXT;
					end
				end
				ST_NEXT: begin
					if (steps == '0)
						state <= ST_READY;
					else begin
						phase_en <= 1'b1;
						steps    <= steps - 1'b1;
						state    <= ST_WAIT_LO;
					end
				end
				ST_WAIT_LO: if (!phase_done) state <= ST_WAIT_HI; // PLL took the step
				ST_WAIT_HI: if (phase_done) state <= ST_NEXT;
				ST_READY: begin
					ready <= 1'b1;
					if (!sdram_sz[15])
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// no new request until the PLL has dropped and raised phase_done
	a_one_step_at_a_time: assert property (@(posedge clk) disable iff (reset)
		phase_en |=> (!phase_en throughout ((!phase_done) [->1] ##1 phase_done [->1])))
		else $error("phase_en while a step is outstanding");

endmodule

// File: src/sys_regs.sv
`timescale 1ns/1ps
`include "hps_macros.svh"

module sys_regs import hps_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_stb,
	input  logic [5:0]            wr_idx,
	input  hps_cmd_t              wr_cmd,
	input  logic [15:0]           wr_data,
	input  logic                  frame_end,
	input  logic [11:0]           scr_hbl_l,
	input  logic [11:0]           scr_hbl_r,
	input  logic [11:0]           scr_hsize,
	input  logic [11:0]           scr_vbl_t,
	input  logic [11:0]           scr_vbl_b,
	input  logic [11:0]           scr_vsize,
	input  logic [6:0]            scr_flg,
	input  logic [1:0]            scr_res,
	input  logic [`HPS_NRES_W-1:0] vid_nres,
	input  logic [`HPS_VID_W-1:0] vid_hcnt,
	input  logic [`HPS_VID_W-1:0] vid_vcnt,
	input  logic [`HPS_VID_W-1:0] vid_htime,
	input  logic [`HPS_VID_W-1:0] vid_vtime,
	output logic [15:0]           io_dout,
	output logic [63:0]           rtc,
	output logic [15:0]           sdram_sz,
	output logic [11:0]           shbl_l,
	output logic [11:0]           shbl_r,
	output logic [11:0]           svbl_t,
	output logic [11:0]           svbl_b,
	output logic                  sset
);

	logic [15:0] rd_val;

	// answer for the word being accepted, zero unless a readback frame
	always_comb begin
		rd_val = '0;
		case (wr_cmd)
			CMD_CAP_A, CMD_CAP_B: begin
				if (wr_idx == 6'd0)
					rd_val = 16'd1;
			end
			CMD_UART_FLAGS: begin
				if (wr_idx != 6'd0)
					rd_val = `HPS_UART_FLAGS;
			end
			CMD_SCREEN_INFO: begin
				case (wr_idx)
					6'd1: rd_val = {1'b1, scr_flg, 6'd0, scr_res};
					6'd2: rd_val = 16'(scr_hsize);
					6'd3: rd_val = 16'(scr_vsize);
					6'd4: rd_val = 16'(scr_hbl_l);
					6'd5: rd_val = 16'(scr_hbl_r);
					6'd6: rd_val = 16'(scr_vbl_t);
					6'd7: rd_val = 16'(scr_vbl_b);
					default: ;
				endcase
			end
			CMD_VIDEO_INFO: begin
				case (wr_idx)
					6'd1: rd_val = 16'(vid_nres);
					6'd2: rd_val = vid_hcnt[15:0];
					6'd3: rd_val = vid_hcnt[31:16];
					6'd4: rd_val = vid_vcnt[15:0];
					6'd5: rd_val = vid_vcnt[31:16];
					6'd6: rd_val = vid_htime[15:0];
					6'd7: rd_val = vid_htime[31:16];
					6'd8: rd_val = vid_vtime[15:0];
					6'd9: rd_val = vid_vtime[31:16];
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			io_dout  <= '0;
			sdram_sz <= '0;
			sset     <= 1'b0;
		end else begin
			sset <= frame_end && (wr_cmd == CMD_SCALER_SET); // apply window after the frame closes
			if (wr_stb) begin
				io_dout <= rd_val; // held until the next word
				if (wr_cmd == CMD_SDRAM_SIZE && wr_idx == 6'd1)
					sdram_sz <= wr_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_stb) begin
			// rtc words fill the 64-bit value from the low end
			if (wr_cmd == CMD_RTC && wr_idx >= 6'd1 && wr_idx <= 6'd4)
				rtc[{wr_idx[1:0] - 2'd1, 4'd0} +: 16] <= wr_data;

			if (wr_cmd == CMD_SCALER_SET) begin
				case (wr_idx)
					6'd1: shbl_l <= wr_data[11:0];
					6'd2: shbl_r <= wr_data[11:0];
					6'd3: svbl_t <= wr_data[11:0];
					6'd4: svbl_b <= wr_data[11:0];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: src/vid_measure.sv
`timescale 1ns/1ps
`include "hps_macros.svh"

module vid_measure (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ce_pix,
	input  logic                   de,
	input  logic                   hs,
	input  logic                   vs,
	output logic [`HPS_NRES_W-1:0] nres,
	output logic [`HPS_VID_W-1:0]  hcnt,
	output logic [`HPS_VID_W-1:0]  vcnt,
	output logic [`HPS_VID_W-1:0]  htime,
	output logic [`HPS_VID_W-1:0]  vtime
);

	localparam int VW = `HPS_VID_W;
	localparam int RW = $clog2(`HPS_RESTABLE_FRAMES + 1);

	logic          pvs, pde; // previous vs/de at pixel rate
	logic          calch;    // still inside the first active line
	logic [VW-1:0] hacc, vacc;
	logic [RW-1:0] resto;    // frames the new size has held

	logic          hs_q, vs_q;
	logic [VW-1:0] htick, vtick;
	logic [VW-1:0] hlast, vlast;

	// pixel-rate size counting, results taken at the end of vsync
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pvs   <= 1'b0;
			pde   <= 1'b0;
			calch <= 1'b0;
			hacc  <= '0;
			vacc  <= '0;
			resto <= '0;
			nres  <= '0;
			hcnt  <= '0;
			vcnt  <= '0;
			htime <= '0;
			vtime <= '0;
		end else if (ce_pix) begin
			pvs <= vs;
			pde <= de;

			if (~vs & ~pde & de)
				vacc <= vacc + 1'b1; // one more active line
			if (calch & de)
				hacc <= hacc + 1'b1;
			if (pde & ~de)
				calch <= 1'b0;

			if (pvs & ~vs) begin
				if (hacc != '0 && vacc != '0) begin
					if (hacc != hcnt || vacc != vcnt)
						resto <= RW'(1); // size moved, start over
					else if (resto == RW'(`HPS_RESTABLE_FRAMES)) begin
						resto <= '0;
						nres  <= nres + 1'b1;
					end else if (resto != '0)
						resto <= resto + 1'b1;
					hcnt <= hacc;
					vcnt <= vacc;
				end
				htime <= hlast;
				vtime <= vlast;
				hacc  <= '0;
				vacc  <= '0;
				calch <= 1'b1;
			end
		end
	end

	// sync periods in system clocks
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hs_q  <= 1'b0;
			vs_q  <= 1'b0;
			htick <= '0;
			vtick <= '0;
			hlast <= '0;
			vlast <= '0;
		end else begin
			hs_q  <= hs;
			vs_q  <= vs;
			htick <= htick + 1'b1;
			vtick <= vtick + 1'b1;
			if (hs & ~hs_q) begin
				hlast <= htick;
				htick <= VW'(1); // the edge cycle is the first of the next period
			end
			if (vs & ~vs_q) begin
				vlast <= vtick;
				vtick <= VW'(1);
			end
		end
	end

endmodule

// File: tb.f
+incdir+include
src/hps_pkg.sv
src/io_frame_decoder.sv
src/input_regs.sv
src/sys_regs.sv
src/vid_measure.sv
src/phase_shift.sv
src/hps_io_top.sv
verif/hps_io_tb.sv

// File: verif/hps_io_tb.sv
`timescale 1ns/1ps
`include "hps_macros.svh"

module hps_io_tb import hps_pkg::*; ();

	localparam int HBLANK     = 16; // hsync, back and front porch per line
	localparam int VBLANK     = 4;  // two vsync lines plus one porch line each side
	localparam int OLD_W      = 40;
	localparam int OLD_H      = 6;
	localparam int OLD_FRAMES = 4;
	localparam int NEW_W      = 32;
	localparam int NEW_H      = 8;
	localparam int NEW_FRAMES = `HPS_RESTABLE_FRAMES + 2;
	localparam int N_FRAMES   = 35; // host frames over the whole run
	localparam int VID_CYCLES = OLD_FRAMES * (OLD_W + HBLANK) * (OLD_H + VBLANK)
		+ NEW_FRAMES * (NEW_W + HBLANK) * (NEW_H + VBLANK);
	localparam int MAX_CYCLES = N_FRAMES * 20 + VID_CYCLES + 2000;

	logic        clk = 1'b0;
	logic        reset;
	logic        io_ena, io_strobe;
	logic [15:0] io_din, io_dout;
	logic        io_wait;
	logic [15:0] joy0, joy1, joy2, joy3;
	logic [1:0]  buttons;
	logic [3:0]  conf;
	logic [2:0]  mouse_buttons;
	logic        kbd_mouse_strobe, kms_level;
	kms_type_t   kbd_mouse_type;
	logic [7:0]  kbd_mouse_data;
	logic        ce_pix, de, hs, vs;
	logic [11:0] scr_hbl_l, scr_hbl_r, scr_hsize, scr_vbl_t, scr_vbl_b, scr_vsize;
	logic [6:0]  scr_flg;
	logic [1:0]  scr_res;
	logic [11:0] shbl_l, shbl_r, svbl_t, svbl_b;
	logic        sset;
	logic [15:0] sdram_sz;
	logic [63:0] rtc;
	logic        pll_locked;
	logic        phase_done = 1'b1;
	logic        phase_en, updn, ready;

	// expected state built from the frames sent
	logic [15:0] exp_joy [4];
	logic [1:0]  exp_buttons = '0;
	logic [3:0]  exp_conf = '0;
	logic [2:0]  exp_mbtn = '0;
	logic [15:0] exp_sdram = '0;
	logic [63:0] exp_rtc;
	logic [11:0] exp_sc [4];
	logic        rtc_valid = 1'b0;
	logic        sc_valid = 1'b0;
	logic        exp_updn = 1'b0;
	logic        exp_lvl = 1'b0;
	logic [7:0]  exp_nres = '0;
	logic [31:0] exp_hcnt, exp_vcnt, exp_htime, exp_vtime;
	logic [1:0]  ev_type_q [$];
	logic [7:0]  ev_data_q [$];

	logic [15:0] fw [16]; // words of the frame to send
	logic [15:0] sz_list [6];
	logic [31:0] rng = 32'h51d2;
	logic [2:0]  pll_dly = '0;
	int          ev_pushed = 0;
	int          ev_seen = 0;
	int          sset_exp = 0;
	int          sset_seen = 0;
	int          pulses = 0;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;

	hps_io_top u_dut (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] rand16();
		rng = xorshift(rng);
		return rng[15:0];
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// answer expected on io_dout after word idx of a frame
	function automatic logic [15:0] ref_dout(input hps_cmd_t cmd, input int idx);
		logic [15:0] v;
		logic [31:0] m [4];
		logic [31:0] mv;
		v = 16'h0000;
		m[0] = exp_hcnt;
		m[1] = exp_vcnt;
		m[2] = exp_htime;
		m[3] = exp_vtime;
		case (cmd)
			CMD_CAP_A, CMD_CAP_B: if (idx == 0) v = 16'h0001;
			CMD_UART_FLAGS: if (idx > 0) v = `HPS_UART_FLAGS;
			CMD_SCREEN_INFO: begin
				case (idx)
					1: v = 16'h8000 | (16'(scr_flg) << 8) | 16'(scr_res);
					2: v = 16'(scr_hsize);
					3: v = 16'(scr_vsize);
					4: v = 16'(scr_hbl_l);
					5: v = 16'(scr_hbl_r);
					6: v = 16'(scr_vbl_t);
					7: v = 16'(scr_vbl_b);
					default: ;
				endcase
			end
			CMD_VIDEO_INFO: begin
				if (idx == 1)
					v = 16'(exp_nres);
				else if (idx >= 2 && idx <= 9) begin
					mv = m[(idx - 2) / 2];
					v  = (idx % 2 == 0) ? mv[15:0] : mv[31:16]; // low half first
				end
			end
			default: ;
		endcase
		return v;
	endfunction

	// register and event effects of one accepted word
	task automatic model_word(input hps_cmd_t cmd, input int idx, input logic [15:0] d);
		if (idx == 1) begin
			case (cmd)
				CMD_JOY0: exp_joy[0] = d;
				CMD_JOY1: exp_joy[1] = d;
				CMD_JOY2: exp_joy[2] = d;
				CMD_JOY3: exp_joy[3] = d;
				CMD_BUTTONS: begin
					exp_buttons = d[1:0];
					exp_conf    = d[7:4];
				end
				CMD_MOUSE: begin
					ev_type_q.push_back(KMS_MOUSE_X);
					ev_data_q.push_back(d[7:0]);
					ev_pushed++;
				end
				CMD_KEYBOARD: begin
					ev_type_q.push_back(KMS_KEYCODE);
					ev_data_q.push_back(d[7:0]);
					ev_pushed++;
				end
				CMD_OSD_KBD: begin
					ev_type_q.push_back(KMS_OSD_KEY);
					ev_data_q.push_back(d[7:0]);
					ev_pushed++;
				end
				CMD_SDRAM_SIZE: exp_sdram = d;
				default: ;
			endcase
		end
		if (cmd == CMD_MOUSE && idx == 2) begin
			ev_type_q.push_back(KMS_MOUSE_Y);
			ev_data_q.push_back(d[7:0]);
			ev_pushed++;
		end
		if (cmd == CMD_MOUSE && idx == 3)
			exp_mbtn = d[2:0];
		if (cmd == CMD_RTC && idx >= 1 && idx <= 4) begin
			exp_rtc[16 * (idx - 1) +: 16] = d;
			rtc_valid = 1'b1;
		end
		if (cmd == CMD_SCALER_SET && idx >= 1 && idx <= 4) begin
			exp_sc[idx - 1] = d[11:0];
			sc_valid = 1'b1;
		end
	endtask

	function automatic int ref_steps(input logic [15:0] sz);
		int p;
		if (sz[14])
			return int'(sz[7:0]); // debug mode
		case (sz[1:0])
			2'd0: p = 0;
			2'd1: p = `HPS_PH32;
			2'd2: p = `HPS_PH64;
			default: p = `HPS_PH128;
		endcase
		return (p < 0) ? -p : p;
	endfunction

	function automatic logic ref_updn(input logic [15:0] sz, input logic prev);
		int p;
		if (sz[14])
			return sz[8];
		case (sz[1:0])
			2'd0: return prev; // no steps, direction left alone
			2'd1: p = `HPS_PH32;
			2'd2: p = `HPS_PH64;
			default: p = `HPS_PH128;
		endcase
		return (p >= 0);
	endfunction

	// resolution changes reported after a run of equal frames
	function automatic int nres_gain(input int frames);
		return (frames - 1 > `HPS_RESTABLE_FRAMES) ? 1 : 0;
	endfunction

	task automatic send_frame(input int n);
		hps_cmd_t cmd;
		cmd = hps_cmd_t'(fw[0][7:0]);
		for (int i = 0; i < n; i++) begin
			model_word(cmd, i, fw[i]);
			@(posedge clk);
			io_ena    <= 1'b1;
			io_strobe <= 1'b1;
			io_din    <= fw[i];
			@(posedge clk);
			io_strobe <= 1'b0;
			@(negedge clk);
			while (io_wait)
				@(negedge clk);
			check_val("io_dout", io_dout, ref_dout(cmd, i));
		end
		@(posedge clk);
		io_ena <= 1'b0;
		if (cmd == CMD_SCALER_SET)
			sset_exp++;
		repeat (5) @(posedge clk); // room for frame_end and sset
	endtask

	task automatic send_random(input hps_cmd_t cmd, input int n);
		fw[0] = 16'(cmd);
		for (int i = 1; i < n; i++)
			fw[i] = rand16();
		send_frame(n);
	endtask

	task automatic check_regs();
		@(negedge clk);
		check_val("joy0", joy0, exp_joy[0]);
		check_val("joy1", joy1, exp_joy[1]);
		check_val("joy2", joy2, exp_joy[2]);
		check_val("joy3", joy3, exp_joy[3]);
		check_val("buttons", buttons, exp_buttons);
		check_val("conf", conf, exp_conf);
		check_val("mouse_buttons", mouse_buttons, exp_mbtn);
		check_val("sdram_sz", sdram_sz, exp_sdram);
		check_val("sset pulse count", sset_seen, sset_exp);
		check_val("kbd_mouse_strobe count", ev_seen, ev_pushed);
		if (rtc_valid)
			check_val("rtc", rtc, exp_rtc);
		if (sc_valid) begin
			check_val("shbl_l", shbl_l, exp_sc[0]);
			check_val("shbl_r", shbl_r, exp_sc[1]);
			check_val("svbl_t", svbl_t, exp_sc[2]);
			check_val("svbl_b", svbl_b, exp_sc[3]);
		end
	endtask

	// frames of w x h active pixels, back to back, one pixel per clk
	task automatic run_video(input int w, input int h, input int frames);
		int ht, vt;
		ht = w + HBLANK;
		vt = h + VBLANK;
		for (int f = 0; f < frames; f++) begin
			for (int y = 0; y < vt; y++) begin
				for (int x = 0; x < ht; x++) begin
					@(posedge clk);
					hs <= (x < 4);
					vs <= (y < 2);
					de <= (y >= 3) && (y < 3 + h) && (x >= 8) && (x < 8 + w);
				end
			end
		end
		@(posedge clk);
		hs <= 1'b0;
		vs <= 1'b0;
		de <= 1'b0;
	endtask

	task automatic expect_video(input int w, input int h, input int frames);
		exp_hcnt  = w;
		exp_vcnt  = h;
		exp_htime = w + HBLANK;
		exp_vtime = (w + HBLANK) * (h + VBLANK);
		exp_nres  = exp_nres + 8'(nres_gain(frames));
	endtask

	// PLL: phase_done drops two cycles after a request, back three later
	always @(posedge clk) begin
		if (reset) begin
			pll_dly    <= '0;
			phase_done <= 1'b1;
		end else if (phase_en)
			pll_dly <= 3'd1;
		else if (pll_dly != 3'd0) begin
			pll_dly <= pll_dly + 3'd1;
			if (pll_dly == 3'd1)
				phase_done <= 1'b0;
			if (pll_dly == 3'd4) begin
				phase_done <= 1'b1;
				pll_dly    <= '0;
			end
		end
	end

	// compares events and counts pulses as they happen
	always @(negedge clk) begin
		if (!reset) begin
			if (kbd_mouse_strobe) begin
				ev_seen++;
				exp_lvl = ~exp_lvl;
				assert (ev_type_q.size() != 0) else begin
					errors++;
					$display("keyboard/mouse event at %0t ns with none expected", $time);
				end
				if (ev_type_q.size() != 0) begin
					check_val("kbd_mouse_type", kbd_mouse_type, ev_type_q.pop_front());
					check_val("kbd_mouse_data", kbd_mouse_data, ev_data_q.pop_front());
				end
			end
			check_val("kms_level", kms_level, exp_lvl);
			if (sset) begin
				sset_seen++;
				assert (!io_ena) else begin
					errors++;
					$display("sset pulsed at %0t ns while the frame was still open", $time);
				end
			end
			if (phase_en)
				pulses++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout after %0d cycles with %0d checks and %0d errors, never finished",
				cycles, checks, errors);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		reset      = 1'b1;
		io_ena     = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		ce_pix     = 1'b1;
		de         = 1'b0;
		hs         = 1'b0;
		vs         = 1'b0;
		pll_locked = 1'b0;
		scr_hbl_l  = '0;
		scr_hbl_r  = '0;
		scr_hsize  = '0;
		scr_vbl_t  = '0;
		scr_vbl_b  = '0;
		scr_vsize  = '0;
		scr_flg    = '0;
		scr_res    = '0;
		for (int i = 0; i < 4; i++)
			exp_joy[i] = '0;
		repeat (3) @(posedge clk);
		reset     <= 1'b0;
		scr_hbl_l <= 12'(rand16());
		scr_hbl_r <= 12'(rand16());
		scr_hsize <= 12'(rand16());
		scr_vbl_t <= 12'(rand16());
		scr_vbl_b <= 12'(rand16());
		scr_vsize <= 12'(rand16());
		scr_flg   <= 7'(rand16());
		scr_res   <= 2'(rand16());

		// joystick, button and config registers
		for (int r = 0; r < 2; r++) begin
			send_random(CMD_JOY0, 2);
			send_random(CMD_JOY1, 2);
			send_random(CMD_JOY2, 2);
			send_random(CMD_JOY3, 2);
			send_random(CMD_BUTTONS, 2);
			check_regs();
		end

		// keyboard and mouse events, extra keyboard word raises nothing
		send_random(CMD_KEYBOARD, 2);
		send_random(CMD_OSD_KBD, 2);
		send_random(CMD_MOUSE, 4);
		send_random(CMD_KEYBOARD, 3);
		check_regs();

		send_random(CMD_RTC, 5);
		fw[0] = 16'(CMD_SDRAM_SIZE);
		fw[1] = rand16() & 16'h7fff; // keep the phase sequencer idle
		send_frame(2);
		send_random(CMD_SCALER_SET, 5);
		check_regs();

		// readback frames
		send_random(CMD_SCREEN_INFO, 8);
		send_random(CMD_UART_FLAGS, 3);
		send_random(CMD_CAP_A, 2);
		send_random(CMD_CAP_B, 2);

		// video timing and resolution change
		run_video(OLD_W, OLD_H, OLD_FRAMES);
		expect_video(OLD_W, OLD_H, OLD_FRAMES);
		send_random(CMD_VIDEO_INFO, 10);
		run_video(NEW_W, NEW_H, NEW_FRAMES);
		expect_video(NEW_W, NEW_H, NEW_FRAMES);
		send_random(CMD_VIDEO_INFO, 10);

		// PLL phase stepping in debug and table mode
		sz_list[0] = 16'hc100 | 16'(rand16() % 16'd6 + 16'd1);
		sz_list[1] = 16'hc000 | 16'(rand16() % 16'd6 + 16'd1);
		sz_list[2] = 16'h8001;
		sz_list[3] = 16'h8002;
		sz_list[4] = 16'h8003;
		sz_list[5] = 16'h8000;
		@(posedge clk);
		pll_locked <= 1'b1;
		for (int c = 0; c < 6; c++) begin
			pulses = 0;
			fw[0]  = 16'(CMD_SDRAM_SIZE);
			fw[1]  = sz_list[c];
			send_frame(2);
			@(negedge clk);
			while (!ready)
				@(negedge clk);
			exp_updn = ref_updn(sz_list[c], exp_updn);
			check_val("phase_en pulse count", pulses, ref_steps(sz_list[c]));
			check_val("updn", updn, exp_updn);
			fw[1] = sz_list[c] & 16'h7fff; // release, sequencer returns to idle
			send_frame(2);
			while (ready)
				@(negedge clk);
			check_regs();
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
